// ==== src.f ====
logic/dbg_info_pkg.sv
logic/dbg_ack_sync.sv
logic/dbg_snap_capture.sv
logic/dbg_fifo_read.sv
logic/dbg_info_top.sv
tests/tb_dbg_info.sv

// ==== Makefile ====
# Verilator build for the debug-info snapshot unit

SIM      = verilator
TOP      = tb_dbg_info
FILELIST = src.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(OBJ_DIR)

# pass only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_dbg_info.sv ====
// testbench for dbg_info_top with two cores
// checks are concurrent assertions against a reference record kept here
// info is held stable while an acknowledge is high, except in test 3 on purpose

`timescale 1ns/10ps
`default_nettype none

module tb_dbg_info;

  import dbg_info_pkg::*;

  localparam int          NUM_TESTS   = 5;
  localparam int          CYCLES_EACH = 200;
  localparam logic [31:0] SEED        = 32'hcfba1a2c;

  logic        dbginfo_clk;
  logic        cpurst_b;
  logic [1:0]  dbg_ack_pc;
  ciu_info_t   ciu_info;
  l2c_info_t   l2c_info;
  logic        read_ren;
  dbg_word_t   dbgfifo2_data;

  // reference state
  dbg_snap_t   exp_snap;
  dbg_word_t   exp_data;
  int          exp_ptr;
  logic        ack_any_q;
  // bookkeeping
  int          err_count;
  int          err_mark;
  int          test_num;
  int          pass_count;
  int          fail_count;

  dbg_info_top #(
    .NUM_CORES (2)
  ) UUT (
    .dbginfo_clk   (dbginfo_clk),
    .cpurst_b      (cpurst_b),
    .dbg_ack_pc    (dbg_ack_pc),
    .ciu_info      (ciu_info),
    .l2c_info      (l2c_info),
    .read_ren      (read_ren),
    .dbgfifo2_data (dbgfifo2_data)
  );

  // 8 ns period
  always #4 dbginfo_clk = ~dbginfo_clk;

  // ==========================================================
  // reference model
  // ==========================================================
  // record is {47 zeros, l2c, ciu}, word i is bits 64i+63:64i
  function automatic dbg_word_t expected_word(input dbg_snap_t rec, input int idx);
    logic [383:0] padded;
    padded          = '0;
    padded[292:0]   = rec.ciu;
    padded[336:293] = rec.l2c;
    return padded[64*idx +: 64];
  endfunction

  // capture on rise of the driven combined level, pointer wraps at 6
  always @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      ack_any_q <= 1'b0;
      exp_snap  <= '0;
      exp_data  <= '0;
      exp_ptr   <= 0;
    end
    else
    begin
      ack_any_q <= |dbg_ack_pc;
      if ((|dbg_ack_pc) && !ack_any_q)
        exp_snap <= {l2c_info, ciu_info};
      if (read_ren)
      begin
        exp_data <= expected_word(exp_snap, exp_ptr);
        exp_ptr  <= (exp_ptr == 5) ? 0 : exp_ptr + 1;
      end
    end
  end

  task automatic report_mismatch(input string name, input dbg_word_t exp_v,
                                 input dbg_word_t act_v);
    $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp_v, act_v);
    err_count++;
  endtask

  // ==========================================================
  // checks
  // ==========================================================
  // output register cleared by reset
  a_reset_zero: assert property (
    @(posedge dbginfo_clk) $rose(cpurst_b) |-> (dbgfifo2_data == '0)
  ) else report_mismatch("dbgfifo2_data", '0, $sampled(dbgfifo2_data));

  // one cycle latency, word from reference record
  a_read_word: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
    read_ren |=> (dbgfifo2_data == exp_data)
  ) else report_mismatch("dbgfifo2_data", $sampled(exp_data), $sampled(dbgfifo2_data));

  // top 47 bits of word 5 are padding
  a_pad_zero: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
    (read_ren && exp_ptr == 5) |=> (dbgfifo2_data[63:17] == '0)
  ) else report_mismatch("dbgfifo2_data[63:17]", '0, 64'($sampled(dbgfifo2_data[63:17])));

  // ==========================================================
  // stimulus helpers
  // ==========================================================
  function automatic ciu_info_t random_ciu();
    logic [319:0] raw;
    for (int i = 0; i < 10; i++)
      raw[32*i +: 32] = $urandom();
    return raw[292:0];
  endfunction

  task automatic drive_info();
    @(posedge dbginfo_clk);
    ciu_info <= random_ciu();
    l2c_info <= l2c_info_t'({$urandom(), $urandom()});
  endtask

  task automatic set_ack(input int core, input logic level);
    @(posedge dbginfo_clk);
    dbg_ack_pc[core] <= level;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge dbginfo_clk);
  endtask

  // strobes spaced by one idle cycle, or on consecutive edges
  task automatic read_words(input int count, input bit back_to_back);
    for (int i = 0; i < count; i++)
    begin
      @(posedge dbginfo_clk);
      read_ren <= 1'b1;
      if (!back_to_back || i == count - 1)
      begin
        @(posedge dbginfo_clk);
        read_ren <= 1'b0;
      end
    end
  endtask

  // let the last check fire, then score the test
  task automatic close_test(input string name);
    idle(3);
    test_num++;
    if (err_count == err_mark)
    begin
      pass_count++;
      $display("test %0d (%s) ok", test_num, name);
    end
    else
    begin
      fail_count++;
      $display("test %0d (%s) failed with %0d errors", test_num, name, err_count - err_mark);
    end
    err_mark = err_count;
  endtask

  // ==========================================================
  // watchdog
  // ==========================================================
  initial
  begin
    repeat (NUM_TESTS * CYCLES_EACH) @(posedge dbginfo_clk);
    $display("timeout: tests did not finish within %0d cycles", NUM_TESTS * CYCLES_EACH);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==========================================================
  // test sequence
  // ==========================================================
  initial
  begin
    void'($urandom(SEED));
    dbginfo_clk = 1'b0;
    cpurst_b    = 1'b0;
    dbg_ack_pc  = '0;
    ciu_info    = '0;
    l2c_info    = '0;
    read_ren    = 1'b0;
    err_count   = 0;
    err_mark    = 0;
    test_num    = 0;
    pass_count  = 0;
    fail_count  = 0;
    idle(10);
    cpurst_b <= 1'b1;

    // nothing captured yet
    read_words(6, 1'b0);
    close_test("reset state");

    // capture lands two edges after the sync
    drive_info();
    set_ack(0, 1'b1);
    idle(4);
    read_words(6, 1'b0);
    close_test("capture and read-out");

    // held level, changed info, same record
    drive_info();
    idle(4);
    read_words(6, 1'b1);
    close_test("held level");

    // overlap then core 1 alone
    set_ack(1, 1'b1);
    idle(4);
    read_words(6, 1'b0);
    set_ack(0, 1'b0);
    set_ack(1, 1'b0);
    idle(5);
    drive_info();
    set_ack(1, 1'b1);
    idle(4);
    read_words(6, 1'b0);
    set_ack(1, 1'b0);
    close_test("overlap and second core");

    // seventh read back at word 0
    read_words(3, 1'b1);
    read_words(2, 1'b0);
    read_words(2, 1'b1);
    close_test("pointer wrap");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/dbg_info_top.sv ====
// debug-info snapshot unit, top level
// one acknowledge level per core, each synchronized separately
// ciu_info and l2c_info must hold stable while any acknowledge is high
// runs directly on dbginfo_clk, no clock gating

`timescale 1ns/10ps
`default_nettype none

module dbg_info_top #(
  parameter int NUM_CORES = 2
) (
  input  logic                    dbginfo_clk,
  input  logic                    cpurst_b,
  // per-core stopped-for-debug levels, asynchronous
  input  logic [NUM_CORES-1:0]    dbg_ack_pc,
  input  dbg_info_pkg::ciu_info_t ciu_info,
  input  dbg_info_pkg::l2c_info_t l2c_info,
  // one-cycle read strobe from the debugger
  input  logic                    read_ren,
  output dbg_info_pkg::dbg_word_t dbgfifo2_data
);

  import dbg_info_pkg::*;

  // synchronized acknowledge levels, bit k from core k
  logic [NUM_CORES-1:0] ack_sync;
  // captured record
  dbg_snap_t            snap;

  // ==========================================================
  // acknowledge synchronizers
  // ==========================================================
  for (genvar k = 0; k < NUM_CORES; k++)
  begin : g_core
    dbg_ack_sync u_ack_sync (
      .dbginfo_clk (dbginfo_clk),
      .cpurst_b    (cpurst_b),
      .ack_in      (dbg_ack_pc[k]),
      .ack_sync    (ack_sync[k])
    );
  end

  // ==========================================================
  // record capture
  // ==========================================================
  dbg_snap_capture #(
    .NUM_CORES (NUM_CORES)
  ) u_snap_capture (
    .dbginfo_clk (dbginfo_clk),
    .cpurst_b    (cpurst_b),
    .ack_sync    (ack_sync),
    .ciu_info    (ciu_info),
    .l2c_info    (l2c_info),
    .snap        (snap)
  );

  // ==========================================================
  // word read-out
  // ==========================================================
  // debugger side, strobe may come every cycle
  dbg_fifo_read u_fifo_read (
    .dbginfo_clk   (dbginfo_clk),
    .cpurst_b      (cpurst_b),
    .snap          (snap),
    .read_ren      (read_ren),
    .dbgfifo2_data (dbgfifo2_data)
  );

endmodule

`default_nettype wire

// ==== logic/dbg_fifo_read.sv ====
// word-wise read-out of the captured debug record
// one word per read strobe, one cycle latency, pointer wraps after the last word
// a new capture leaves the pointer where it is

`timescale 1ns/10ps
`default_nettype none

module dbg_fifo_read (
  input  logic                    dbginfo_clk,
  input  logic                    cpurst_b,
  input  dbg_info_pkg::dbg_snap_t snap,
  input  logic                    read_ren,
  output dbg_info_pkg::dbg_word_t dbgfifo2_data
);

  import dbg_info_pkg::*;

  // record zero-extended to whole words
  logic [DBG_PAD_WIDTH-1:0] snap_pad;
  // record split into words, word 0 at the bottom
  dbg_word_t                snap_word [DBG_DEPTH];
  // read pointer and its wrap condition
  dbg_rptr_t                rptr;
  logic                     rptr_last;

  // ==========================================================
  // padding and word split
  // ==========================================================
  // top bits of the last word read as zero
  assign snap_pad = {{(DBG_PAD_WIDTH-DBG_SNAP_WIDTH){1'b0}}, snap};

  for (genvar i = 0; i < DBG_DEPTH; i++)
  begin : g_word
    assign snap_word[i] = snap_pad[DBG_WORD_WIDTH*i +: DBG_WORD_WIDTH];
  end

  // ==========================================================
  // output register
  // ==========================================================
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dbgfifo2_data <= '0;
    else if (read_ren)
      dbgfifo2_data <= snap_word[rptr];
  end

  // ==========================================================
  // read pointer
  // ==========================================================
  assign rptr_last = (rptr == dbg_rptr_t'(DBG_DEPTH-1));

  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rptr <= '0;
    end
    else if (read_ren)
    begin
      // back to word 0 after the last one
      if (rptr_last)
        rptr <= '0;
      else
        rptr <= rptr + 1'b1;
    end
  end

  // ==========================================================
  // checks
  // ==========================================================
  // strobe always driven, an unknown would corrupt the pointer
  a_ren_known: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
    !$isunknown(read_ren)
  );

endmodule

`default_nettype wire

// ==== logic/dbg_snap_capture.sv ====
// captures one debug record on the first rise of the combined acknowledge
// inputs must hold stable while any acknowledge is high
// a core rising while another is already high does not recapture

`timescale 1ns/10ps
`default_nettype none

module dbg_snap_capture #(
  parameter int NUM_CORES = 2
) (
  input  logic                   dbginfo_clk,
  input  logic                   cpurst_b,
  input  logic [NUM_CORES-1:0]   ack_sync,
  input  dbg_info_pkg::ciu_info_t ciu_info,
  input  dbg_info_pkg::l2c_info_t l2c_info,
  output dbg_info_pkg::dbg_snap_t snap
);

  import dbg_info_pkg::*;

  // combined level and its delayed copy
  logic ack_any;
  logic ack_any_f;
  // one-cycle capture strobe
  logic record_pulse;

  // ==========================================================
  // edge detect on the combined acknowledge
  // ==========================================================
  // any stopped core counts
  assign ack_any = |ack_sync;

  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      ack_any_f <= 1'b0;
    else
      ack_any_f <= ack_any;
  end

  // rising edge only
  assign record_pulse = ack_any && !ack_any_f;

  // ==========================================================
  // snapshot register
  // ==========================================================
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      snap <= '0;
    end
    else if (record_pulse)
    begin
      // l2c goes on top, ciu at the bottom
      snap.l2c <= l2c_info;
      snap.ciu <= ciu_info;
    end
  end

  // ==========================================================
  // checks
  // ==========================================================
  // captured info must be driven, not floating
  a_info_known: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
    record_pulse |-> !$isunknown({l2c_info, ciu_info})
  );

  // core count within what the debug block supports
  a_core_bound: assert property (
    @(posedge dbginfo_clk)
    (NUM_CORES >= 1) && (NUM_CORES <= DBG_MAX_CORES)
  );

endmodule

`default_nettype wire

// ==== logic/dbg_ack_sync.sv ====
// two-flop synchronizer for one core's debug acknowledge level
// input is a level asynchronous to dbginfo_clk, output lags it by two edges
// pulses shorter than a clock period may be lost

`timescale 1ns/10ps
`default_nettype none

module dbg_ack_sync (
  input  logic dbginfo_clk,
  input  logic cpurst_b,
  input  logic ack_in,
  output logic ack_sync
);

  // first stage, may go metastable
  logic sync_q1;

  // ==========================================================
  // synchronizer stages
  // ==========================================================
  always_ff @(posedge dbginfo_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      sync_q1  <= 1'b0;
      ack_sync <= 1'b0;
    end
    else
    begin
      // sample the raw level
      sync_q1  <= ack_in;
      // second stage gives the first a full cycle to settle
      ack_sync <= sync_q1;
    end
  end

  // ==========================================================
  // checks
  // ==========================================================
  // a stopped core holds its level, no single-cycle blips
  a_level_hold: assert property (
    @(posedge dbginfo_clk) disable iff (!cpurst_b)
    $changed(ack_sync) |=> $stable(ack_sync)
  );

endmodule

`default_nettype wire

// ==== logic/dbg_info_pkg.sv ====
// shared widths and types for the debug-info snapshot unit
// the record is 44 bits of L2 cache state above 293 bits of interconnect state
// read-out is six 64-bit words, the top 47 bits of word 5 are zero

`default_nettype none

package dbg_info_pkg;

  // ==========================================================
  // widths
  // ==========================================================
  localparam int DBG_CIU_WIDTH  = 293;
  localparam int DBG_L2C_WIDTH  = 44;
  localparam int DBG_SNAP_WIDTH = DBG_L2C_WIDTH + DBG_CIU_WIDTH;
  localparam int DBG_WORD_WIDTH = 64;

  // words per record, and record padded to whole words
  localparam int DBG_DEPTH      = 6;
  localparam int DBG_PAD_WIDTH  = DBG_WORD_WIDTH * DBG_DEPTH;

  // upper bound on acknowledge inputs
  localparam int DBG_MAX_CORES  = 4;

  // ==========================================================
  // vector types
  // ==========================================================
  // interconnect debug state
  typedef logic [DBG_CIU_WIDTH-1:0]  ciu_info_t;
  // L2 cache debug state
  typedef logic [DBG_L2C_WIDTH-1:0]  l2c_info_t;
  // one read-out word
  typedef logic [DBG_WORD_WIDTH-1:0] dbg_word_t;
  // read pointer, 0 to DBG_DEPTH-1
  typedef logic [2:0]                dbg_rptr_t;

  // ==========================================================
  // snapshot record
  // ==========================================================
  // l2c sits in the upper bits, ciu starts at bit 0
  typedef struct packed {
    l2c_info_t l2c;
    ciu_info_t ciu;
  } dbg_snap_t;

endpackage

`default_nettype wire
